/* rtl/pitch_macros.svh */
// Pitch resampler widths and fixed-point constants
// Shared by the package and the RTL blocks
`ifndef PITCH_MACROS_SVH
`define PITCH_MACROS_SVH

`define PITCH_ADDR_W    23  // SDRAM word address
`define PITCH_DATA_W    32  // One stereo word
`define PITCH_SPEED_W   4   // Speed in eighths
`define PITCH_FRAC_BITS 3

// Resample accumulator, integer part is a word index
`define PITCH_ACC_W     (`PITCH_ADDR_W + `PITCH_FRAC_BITS)

`endif

/* rtl/pitch_pkg.sv */
// Pitch resampler types
// SDRAM word views, bus request and pipeline items
`include "pitch_macros.svh"

package pitch_pkg;

    // Header word or stereo sample, same 32 bits
    typedef union packed {
        struct packed {
            logic [`PITCH_DATA_W-`PITCH_ADDR_W-1:0] unused;
            logic [`PITCH_ADDR_W-1:0]               length;
        } header;
        struct packed {
            logic [15:0] left;
            logic [15:0] right;
        } sample;
    } sdram_word_u;

    typedef struct packed {
        logic                     read;
        logic                     write;
        logic [`PITCH_ADDR_W-1:0] addr;
        sdram_word_u              wdata;
    } sdram_req_t;

    typedef struct packed {
        logic [`PITCH_ADDR_W-1:0] src_addr;
        logic [`PITCH_ADDR_W-1:0] dst_addr;
        logic                     silent;  // Index past the input
        logic                     last;
    } index_item_t;

    typedef struct packed {
        logic [`PITCH_ADDR_W-1:0] dst_addr;
        sdram_word_u              word;
        logic                     last;
    } store_item_t;

endpackage

/* rtl/pitch_control.sv */
// Pitch resampler sequencing
// Reads the source header, writes it to the destination, runs the pipeline
`timescale 1ns/1ps
`include "pitch_macros.svh"

module pitch_control (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic                     start,
    input  logic [`PITCH_ADDR_W-1:0] src_base,
    input  logic [`PITCH_ADDR_W-1:0] dst_base,
    output logic                     done,
    output pitch_pkg::sdram_req_t    req,
    input  logic                     finished,
    input  pitch_pkg::sdram_word_u   rdata,
    output logic                     run_start,
    output logic [`PITCH_ADDR_W-1:0] count,
    input  logic                     last_done
);
    localparam logic [2:0] ST_IDLE   = 3'd0;
    localparam logic [2:0] ST_HDR_RD = 3'd1;
    localparam logic [2:0] ST_HDR_WR = 3'd2;
    localparam logic [2:0] ST_RUN    = 3'd3;
    localparam logic [2:0] ST_DONE   = 3'd4;

    logic [2:0]               state;
    logic [`PITCH_ADDR_W-1:0] req_addr;
    pitch_pkg::sdram_word_u   hdr_word;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state     <= ST_IDLE;
            run_start <= 1'b0;
        end else begin
            run_start <= 1'b0;
            case (state)
                ST_IDLE:   if (start) state <= ST_HDR_RD;
                ST_HDR_RD: if (finished) state <= ST_HDR_WR;
                ST_HDR_WR: begin
                    if (finished) begin
                        if (count == '0) begin
                            state <= ST_DONE;  // Nothing to resample
                        end else begin
                            state     <= ST_RUN;
                            run_start <= 1'b1;
                        end
                    end
                end
                ST_RUN:    if (last_done) state <= ST_DONE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == ST_IDLE && start) req_addr <= src_base;
        if (state == ST_HDR_RD && finished) begin
            req_addr <= dst_base;
            count    <= rdata.header.length;
        end
    end

    // Header goes out with the spare bits cleared
    always_comb begin
        hdr_word               = '0;
        hdr_word.header.length = count;
    end

    assign req = '{read: (state == ST_HDR_RD), write: (state == ST_HDR_WR),
                   addr: req_addr, wdata: hdr_word};
    assign done = (state == ST_DONE);

    a_done_cause: assert property (@(posedge i_clk) disable iff (i_rst)
        $rose(done) |-> $past((state == ST_RUN && last_done) ||
                              (state == ST_HDR_WR && finished)));

endmodule

/* rtl/resample_index_gen.sv */
// Resample index generator, pipeline stage 1
// Fixed-point accumulator steps by speed eighths per output word
`timescale 1ns/1ps
`include "pitch_macros.svh"

module resample_index_gen (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic                      run_start,
    input  logic [`PITCH_ADDR_W-1:0]  src_base,
    input  logic [`PITCH_ADDR_W-1:0]  dst_base,
    input  logic [`PITCH_ADDR_W-1:0]  count,
    input  logic [`PITCH_SPEED_W-1:0] speed,
    output pitch_pkg::index_item_t    item,
    output logic                      item_valid,
    input  logic                      taken
);
    logic [`PITCH_ACC_W-1:0]  acc, acc_n;
    logic [`PITCH_ACC_W:0]    acc_sum;
    logic [`PITCH_ADDR_W-1:0] k, k_n;
    logic [`PITCH_ADDR_W-1:0] src_idx;
    logic                     past_end;
    logic                     load;

    assign acc_sum = {1'b0, acc} + {{(`PITCH_ACC_W + 1 - `PITCH_SPEED_W){1'b0}}, speed};
    assign load    = run_start || (taken && !item.last);

    always_comb begin
        if (run_start) begin
            acc_n    = '0;
            k_n      = '0;
            past_end = 1'b0;
        end else begin
            acc_n    = acc_sum[`PITCH_ACC_W-1:0];
            k_n      = k + 1'b1;
            past_end = item.silent || acc_sum[`PITCH_ACC_W];  // Stays silent once past
        end
    end

    assign src_idx = acc_n[`PITCH_ACC_W-1:`PITCH_FRAC_BITS];

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            item_valid <= 1'b0;
        end else if (run_start) begin
            item_valid <= 1'b1;
        end else if (taken && item.last) begin
            item_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (load) begin
            acc           <= acc_n;
            k             <= k_n;
            item.src_addr <= src_base + 1'b1 + src_idx;
            item.dst_addr <= dst_base + 1'b1 + k_n;
            item.silent   <= past_end || (src_idx >= count);
            item.last     <= (k_n == count - 1'b1);
        end
    end

    a_item_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        item_valid && !taken |=> item_valid && $stable(item));

endmodule

/* rtl/sample_fetch.sv */
// Sample fetch, pipeline stage 2
// Reads one source word per item, silent items become a zero word
`timescale 1ns/1ps
`include "pitch_macros.svh"

module sample_fetch (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  pitch_pkg::index_item_t   in_item,
    input  logic                     in_valid,
    output logic                     in_taken,
    output pitch_pkg::sdram_req_t    req,
    input  logic                     finished,
    input  logic [`PITCH_DATA_W-1:0] rdata,
    output pitch_pkg::store_item_t   out_item,
    output logic                     out_valid,
    input  logic                     out_taken
);
    logic                     rd_pending;
    logic [`PITCH_ADDR_W-1:0] rd_src;
    logic [`PITCH_ADDR_W-1:0] rd_dst;
    logic                     rd_last;

    // Only take when the output slot is empty and no read is open
    assign in_taken = in_valid && !rd_pending && !out_valid;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            rd_pending <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            if (in_taken && !in_item.silent) begin
                rd_pending <= 1'b1;
            end else if (rd_pending && finished) begin
                rd_pending <= 1'b0;
            end
            if ((in_taken && in_item.silent) || (rd_pending && finished)) begin
                out_valid <= 1'b1;
            end else if (out_taken) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (in_taken) begin
            rd_src <= in_item.src_addr;
            rd_dst <= in_item.dst_addr;
            rd_last <= in_item.last;
            if (in_item.silent) begin
                out_item <= '{dst_addr: in_item.dst_addr, word: '0, last: in_item.last};
            end
        end else if (rd_pending && finished) begin
            out_item <= '{dst_addr: rd_dst, word: rdata, last: rd_last};
        end
    end

    assign req = '{read: rd_pending, write: 1'b0, addr: rd_src, wdata: '0};

    a_no_silent_read: assert property (@(posedge i_clk) disable iff (i_rst)
        in_taken && in_item.silent |=> !req.read);

endmodule

/* rtl/sample_store.sv */
// Sample store, pipeline stage 3
// Writes each word to the destination and flags the final write
`timescale 1ns/1ps

module sample_store (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  pitch_pkg::store_item_t in_item,
    input  logic                   in_valid,
    output logic                   in_taken,
    output pitch_pkg::sdram_req_t  req,
    input  logic                   finished,
    output logic                   last_done
);
    pitch_pkg::store_item_t held;
    logic                   busy;  // Write in progress

    assign in_taken = in_valid && !busy;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            busy <= 1'b0;
        end else if (in_taken) begin
            busy <= 1'b1;
        end else if (finished) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (in_taken) held <= in_item;
    end

    assign req = '{read: 1'b0, write: busy, addr: held.dst_addr, wdata: held.word};

    // Same cycle as the finished pulse of the last write
    assign last_done = busy && finished && held.last;

endmodule

/* rtl/sdram_port_mux.sv */
// SDRAM port arbiter
// Locks one requester until its finished pulse, store before fetch
`timescale 1ns/1ps

module sdram_port_mux (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  pitch_pkg::sdram_req_t ctrl_req,
    input  pitch_pkg::sdram_req_t fetch_req,
    input  pitch_pkg::sdram_req_t store_req,
    output logic                  ctrl_finished,
    output logic                  fetch_finished,
    output logic                  store_finished,
    output pitch_pkg::sdram_req_t bus_req,
    input  logic                  bus_finished
);
    localparam logic [1:0] G_NONE  = 2'd0;
    localparam logic [1:0] G_CTRL  = 2'd1;
    localparam logic [1:0] G_FETCH = 2'd2;
    localparam logic [1:0] G_STORE = 2'd3;

    logic [1:0] grant, sel;

    always_comb begin
        if (grant != G_NONE) begin
            sel = grant;  // Locked until finished
        end else if (store_req.read || store_req.write) begin
            sel = G_STORE;
        end else if (fetch_req.read || fetch_req.write) begin
            sel = G_FETCH;
        end else if (ctrl_req.read || ctrl_req.write) begin
            sel = G_CTRL;
        end else begin
            sel = G_NONE;
        end
    end

    always_comb begin
        case (sel)
            G_CTRL:  bus_req = ctrl_req;
            G_FETCH: bus_req = fetch_req;
            G_STORE: bus_req = store_req;
            default: bus_req = '0;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            grant <= G_NONE;
        end else if (bus_finished) begin
            grant <= G_NONE;
        end else begin
            grant <= sel;
        end
    end

    assign ctrl_finished  = bus_finished && (sel == G_CTRL);
    assign fetch_finished = bus_finished && (sel == G_FETCH);
    assign store_finished = bus_finished && (sel == G_STORE);

    a_one_dir: assert property (@(posedge i_clk) disable iff (i_rst)
        !(bus_req.read && bus_req.write));

    a_req_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        (bus_req.read || bus_req.write) && !bus_finished |=> $stable(bus_req));

endmodule

/* rtl/pitch_resampler.sv */
// Pitch-shift resampler top level
// Control, three-stage index/fetch/store pipeline and SDRAM arbiter
`timescale 1ns/1ps
`include "pitch_macros.svh"

module pitch_resampler (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic                      start,
    input  logic [`PITCH_ADDR_W-1:0]  src_base,
    input  logic [`PITCH_ADDR_W-1:0]  dst_base,
    input  logic [`PITCH_SPEED_W-1:0] speed,
    output logic                      done,
    output pitch_pkg::sdram_req_t     sdram_req,
    input  pitch_pkg::sdram_word_u    sdram_rdata,
    input  logic                      sdram_finished
);
    pitch_pkg::sdram_req_t    ctrl_req, fetch_req, store_req;
    logic                     ctrl_fin, fetch_fin, store_fin;
    logic                     run_start, last_done;
    logic [`PITCH_ADDR_W-1:0] count;
    pitch_pkg::index_item_t   idx_item;
    logic                     idx_valid, idx_taken;
    pitch_pkg::store_item_t   st_item;
    logic                     st_valid, st_taken;

    pitch_control u_control (
        .i_clk, .i_rst, .start, .src_base, .dst_base, .done,
        .req(ctrl_req), .finished(ctrl_fin), .rdata(sdram_rdata),
        .run_start, .count, .last_done
    );

    resample_index_gen u_index (
        .i_clk, .i_rst, .run_start, .src_base, .dst_base, .count, .speed,
        .item(idx_item), .item_valid(idx_valid), .taken(idx_taken)
    );

    sample_fetch u_fetch (
        .i_clk, .i_rst, .in_item(idx_item), .in_valid(idx_valid), .in_taken(idx_taken),
        .req(fetch_req), .finished(fetch_fin), .rdata(sdram_rdata),
        .out_item(st_item), .out_valid(st_valid), .out_taken(st_taken)
    );

    sample_store u_store (
        .i_clk, .i_rst, .in_item(st_item), .in_valid(st_valid), .in_taken(st_taken),
        .req(store_req), .finished(store_fin), .last_done
    );

    sdram_port_mux u_mux (
        .i_clk, .i_rst, .ctrl_req, .fetch_req, .store_req,
        .ctrl_finished(ctrl_fin), .fetch_finished(fetch_fin), .store_finished(store_fin),
        .bus_req(sdram_req), .bus_finished(sdram_finished)
    );

endmodule

/* testbench/tb_pitch_resampler.sv */
// Testbench for the pitch resampler
// SDRAM model with random latency, vectors and sample data from a file
`timescale 1ns/1ps
`include "pitch_macros.svh"

module tb_pitch_resampler;
    localparam logic [`PITCH_ADDR_W-1:0] MEM_WORDS = 23'd1024;

    logic                      i_clk = 1'b0;
    logic                      i_rst;
    logic                      start;
    logic [`PITCH_ADDR_W-1:0]  src_base;
    logic [`PITCH_ADDR_W-1:0]  dst_base;
    logic [`PITCH_SPEED_W-1:0] speed;
    logic                      done;
    pitch_pkg::sdram_req_t     sdram_req;
    pitch_pkg::sdram_word_u    sdram_rdata;
    logic                      sdram_finished;

    logic [31:0]               mem [0:1023];
    logic [`PITCH_SPEED_W-1:0] speed_q[$];
    logic [`PITCH_ADDR_W-1:0]  count_q[$];
    int                        first_q[$];   // First sample of each test
    logic [31:0]               sample_q[$];
    logic [`PITCH_ADDR_W-1:0]  cur_count;
    int seed = 10181;
    int cycle = 0;
    int bus_wait = -1;
    int last_wr_cycle = -10;
    int done_count = 0;
    int write_count = 0;
    int timeout_cycles = 0;

    pitch_resampler UUT (
        .i_clk, .i_rst, .start, .src_base, .dst_base, .speed, .done,
        .sdram_req, .sdram_rdata, .sdram_finished
    );

    always #2 i_clk = ~i_clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "run stopped");
    endtask

    task automatic report_error(input string msg);
        abort_run($sformatf("[FAIL] %0d ns: %s", $time, msg));
    endtask

    function automatic logic [31:0] fill_word(input logic [`PITCH_ADDR_W-1:0] a);
        return 32'h5A5A_0000 ^ {9'd0, a};
    endfunction

    task automatic serve_request();
        logic [`PITCH_ADDR_W-1:0] a;
        a = sdram_req.addr;
        assert (a < MEM_WORDS) else report_error($sformatf("address %0h past the model", a));
        if (sdram_req.write) begin
            assert (a >= dst_base && a <= dst_base + cur_count)
                else report_error($sformatf("write to %0h outside the destination", a));
            mem[a[9:0]] = sdram_req.wdata;
            write_count = write_count + 1;
            last_wr_cycle = cycle;
        end else begin
            assert (a >= src_base && a <= src_base + cur_count)
                else report_error($sformatf("read from %0h outside the source", a));
            sdram_rdata = mem[a[9:0]];
        end
        sdram_finished = 1'b1;
    endtask

    // SDRAM model, finished comes 1 to 4 cycles after the request
    always begin
        @(posedge i_clk);
        #1;
        cycle = cycle + 1;
        sdram_finished = 1'b0;
        if (!i_rst) begin
            if (done) begin
                done_count = done_count + 1;
                assert (cycle == last_wr_cycle + 1)
                    else report_error($sformatf("done %0d cycles after the last write",
                                                cycle - last_wr_cycle));
            end
            if (bus_wait < 0 && (sdram_req.read || sdram_req.write)) begin
                bus_wait = $unsigned($random(seed)) % 4;
            end
            if (bus_wait == 0) begin
                serve_request();
                bus_wait = -1;
            end else if (bus_wait > 0) begin
                bus_wait = bus_wait - 1;
            end
        end
    end

    initial begin
        wait (timeout_cycles > 0);
        repeat (timeout_cycles) @(posedge i_clk);
        abort_run($sformatf("Timeout: tests not finished within %0d cycles", timeout_cycles));
    end

    initial begin
        int fd;
        int n;
        int idx;
        int remaining;
        string line;
        logic [`PITCH_SPEED_W-1:0] spd;
        logic [`PITCH_ADDR_W-1:0]  cnt;
        logic [31:0]               word;
        pitch_pkg::sdram_word_u    got;
        pitch_pkg::sdram_word_u    exp;

        i_rst = 1'b1;
        start = 1'b0;
        src_base = '0;
        dst_base = '0;
        speed = '0;
        sdram_rdata = '0;
        sdram_finished = 1'b0;
        cur_count = '0;
        remaining = 0;

        fd = $fopen("testbench/pitch_input.txt", "r");
        if (fd == 0) abort_run("Cannot open testbench/pitch_input.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") continue;
            if (remaining == 0) begin
                void'($sscanf(line, "%h %h", spd, cnt));
                speed_q.push_back(spd);
                count_q.push_back(cnt);
                first_q.push_back(sample_q.size());
                remaining = int'(cnt);
            end else begin
                void'($sscanf(line, "%h", word));
                sample_q.push_back(word);
                remaining = remaining - 1;
            end
        end
        $fclose(fd);
        if (remaining != 0 || count_q.size() == 0) abort_run("Input file is incomplete");
        foreach (count_q[t]) timeout_cycles += 40 * int'(count_q[t]) + 200;

        repeat (2) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        repeat (5) begin
            @(negedge i_clk);
            assert (!sdram_req.read && !sdram_req.write && !done)
                else report_error("bus or done active without a start");
        end

        foreach (count_q[t]) begin
            n = int'(count_q[t]);
            @(posedge i_clk);
            #1;
            cur_count = count_q[t];
            src_base = 23'h040 + 23'(t * 7);
            dst_base = 23'h200 + 23'(t * 11);
            speed = speed_q[t];
            for (int a = 0; a < 1024; a++) mem[a] = fill_word(23'(a));
            mem[src_base[9:0]] = {9'h1A5, count_q[t]};  // Spare bits set in source
            for (int i = 0; i < n; i++) mem[src_base[9:0] + 10'(i + 1)] = sample_q[first_q[t] + i];
            done_count = 0;
            write_count = 0;
            start = 1'b1;
            @(posedge i_clk);
            #1;
            start = 1'b0;
            if (t == 1) begin
                repeat (2) @(posedge i_clk);  // Header transfer still in flight
                #1;
                start = 1'b1;
                @(posedge i_clk);
                #1;
                start = 1'b0;
            end
            while (done_count == 0) @(negedge i_clk);
            repeat (8) @(negedge i_clk);

            assert (done_count == 1) else report_error($sformatf("%0d done pulses", done_count));
            assert (write_count == n + 1)
                else report_error($sformatf("%0d writes, expected %0d", write_count, n + 1));
            got = mem[dst_base[9:0]];
            assert (got.header.length == count_q[t] && got.header.unused == '0)
                else report_error($sformatf("header %08h for count %0d", got, n));
            for (int k = 0; k < n; k++) begin
                idx = (k * int'(speed_q[t])) / 8;
                exp = (idx < n) ? sample_q[first_q[t] + idx] : 32'd0;  // Silence past the end
                got = mem[dst_base[9:0] + 10'(k + 1)];
                assert (got.sample.left == exp.sample.left && got.sample.right == exp.sample.right)
                    else report_error($sformatf("test %0d word %0d is %08h, expected %08h",
                                                t, k, got, exp));
            end
        end
        $display("Verification passed");
        $finish;
    end

endmodule

/* testbench/pitch_input.txt */
# test line: speed count (hex), speed in eighths of a source word per output word
# then count sample lines: left sample in the upper 16 bits, right in the lower 16
8 6
00110022
10002000
7fff8001
1234abcd
fffe0001
5a5aa5a5
5 5
01000100
02000200
03000300
04000400
05000500
c 5
0a0bf0f1
1c1de2e3
2e2fd4d5
3031c6c7
4243b8b9
8 0

/* pitch_resampler.f */
+incdir+rtl
rtl/pitch_pkg.sv
rtl/pitch_control.sv
rtl/resample_index_gen.sv
rtl/sample_fetch.sv
rtl/sample_store.sv
rtl/sdram_port_mux.sv
rtl/pitch_resampler.sv
testbench/tb_pitch_resampler.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the pitch resampler testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
    --top-module tb_pitch_resampler \
    -f pitch_resampler.f \
    -o tb_pitch_resampler
./obj_dir/tb_pitch_resampler
